/* logic/axi_core_pkg.sv */
////////////////////////////////////////////////////////////
// axi core package
// widths, response codes and single-beat channel structs
// shared by the core bridge, the slices and the ram slave
////////////////////////////////////////////////////////////

package axi_core_pkg;

	localparam int addr_w  = 32;
	localparam int data_w  = 64;
	localparam int strb_w  = data_w / 8;
	localparam int instr_w = 32;

	typedef logic [addr_w-1:0]  addr_t;
	typedef logic [data_w-1:0]  data_t;
	typedef logic [strb_w-1:0]  strb_t;
	typedef logic [instr_w-1:0] instr_t;
	typedef logic [1:0]         resp_t;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

	// load/store command from the core
	typedef struct packed {
		logic  we;
		addr_t addr;
		data_t wdata;
		strb_t strb;
	} mem_cmd_t;

	typedef struct packed {
		addr_t addr;
	} aw_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_t;

	typedef struct packed {
		addr_t addr;
	} ar_t;

	typedef struct packed {
		resp_t resp;
	} b_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} r_t;

endpackage

/* logic/axi_chan_slice.sv */
////////////////////////////////////////////////////////////
// axi channel slice
// one-entry valid/ready register, payload type is a parameter
////////////////////////////////////////////////////////////

module axi_chan_slice #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	logic     full;
	payload_t data_q;

	// take a new beat when empty or when the held one leaves now
	assign in_ready  = !full || out_ready;
	assign out_valid = full;
	assign out_data  = data_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
		end else if (in_ready) begin
			full <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

endmodule

/* logic/axi_core_master.sv */
////////////////////////////////////////////////////////////
// axi core master
// arbitrates the fetch and load/store four-phase ports
// onto single-beat aw/w/b and ar/r, data port first
////////////////////////////////////////////////////////////

module axi_core_master (
	input  logic                     clk,
	input  logic                     rst_n,

	// fetch port
	input  logic                     fetch_req,
	input  axi_core_pkg::addr_t      fetch_pc,
	output logic                     fetch_ack,
	output axi_core_pkg::instr_t     fetch_instr,
	output logic                     fetch_err,

	// load/store port
	input  logic                     mem_req,
	input  axi_core_pkg::mem_cmd_t   mem_cmd,
	output logic                     mem_ack,
	output axi_core_pkg::data_t      mem_rdata,
	output logic                     mem_err,

	// bus
	output logic                     aw_valid,
	output axi_core_pkg::aw_t        aw,
	input  logic                     aw_ready,
	output logic                     w_valid,
	output axi_core_pkg::w_t         w,
	input  logic                     w_ready,
	input  logic                     b_valid,
	input  axi_core_pkg::b_t         b,
	output logic                     b_ready,
	output logic                     ar_valid,
	output axi_core_pkg::ar_t        ar,
	input  logic                     ar_ready,
	input  logic                     r_valid,
	input  axi_core_pkg::r_t         r,
	output logic                     r_ready
);

	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_bresp,
		st_read,
		st_rresp
	} state_t;

	state_t state;
	logic   own_data;
	logic   fetch_hi;
	logic   mem_go;
	logic   fetch_go;

	// a port is eligible once its previous handshake has closed
	assign mem_go   = mem_req && !mem_ack;
	assign fetch_go = fetch_req && !fetch_ack;

	assign b_ready = (state == st_bresp);
	assign r_ready = (state == st_rresp);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			own_data  <= 1'b0;
			aw_valid  <= 1'b0;
			w_valid   <= 1'b0;
			ar_valid  <= 1'b0;
			mem_ack   <= 1'b0;
			fetch_ack <= 1'b0;
		end else begin
			// ack falls after the core drops req
			if (mem_ack && !mem_req) begin
				mem_ack <= 1'b0;
			end
			if (fetch_ack && !fetch_req) begin
				fetch_ack <= 1'b0;
			end

			case (state)
				st_idle: begin
					if (mem_go) begin
						own_data <= 1'b1;
						if (mem_cmd.we) begin
							aw_valid <= 1'b1;
							w_valid  <= 1'b1;
							state    <= st_write;
						end else begin
							ar_valid <= 1'b1;
							state    <= st_read;
						end
					end else if (fetch_go) begin
						own_data <= 1'b0;
						ar_valid <= 1'b1;
						state    <= st_read;
					end
				end
				st_write: begin
					// aw and w handshake independently
					if (aw_ready) begin
						aw_valid <= 1'b0;
					end
					if (w_ready) begin
						w_valid <= 1'b0;
					end
					if ((!aw_valid || aw_ready) && (!w_valid || w_ready)) begin
						state <= st_bresp;
					end
				end
				st_bresp: begin
					if (b_valid) begin
						mem_ack <= 1'b1;
						state   <= st_idle;
					end
				end
				st_read: begin
					if (ar_ready) begin
						ar_valid <= 1'b0;
						state    <= st_rresp;
					end
				end
				st_rresp: begin
					if (r_valid) begin
						if (own_data) begin
							mem_ack <= 1'b1;
						end else begin
							fetch_ack <= 1'b1;
						end
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// request payloads and per-port results
	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			if (mem_go) begin
				aw.addr <= mem_cmd.addr;
				w.data  <= mem_cmd.wdata;
				w.strb  <= mem_cmd.strb;
				ar.addr <= mem_cmd.addr;
			end else if (fetch_go) begin
				ar.addr  <= {fetch_pc[31:3], 3'b000};
				fetch_hi <= fetch_pc[2];
			end
		end
		if (state == st_bresp && b_valid) begin
			mem_err <= (b.resp == axi_core_pkg::resp_slverr);
		end
		if (state == st_rresp && r_valid) begin
			if (own_data) begin
				mem_rdata <= r.data;
				mem_err   <= (r.resp == axi_core_pkg::resp_slverr);
			end else begin
				// upper half for pc bit 2 set
				fetch_instr <= fetch_hi ? r.data[63:32] : r.data[31:0];
				fetch_err   <= (r.resp == axi_core_pkg::resp_slverr);
			end
		end
	end

endmodule

/* logic/axi_ram_slave.sv */
////////////////////////////////////////////////////////////
// axi ram slave
// word ram behind single-beat aw/w/b and ar/r
// slverr for addresses past the end of the array
////////////////////////////////////////////////////////////

module axi_ram_slave #(
	parameter int ram_words = 256
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                aw_valid,
	input  axi_core_pkg::aw_t   aw,
	output logic                aw_ready,
	input  logic                w_valid,
	input  axi_core_pkg::w_t    w,
	output logic                w_ready,
	output logic                b_valid,
	output axi_core_pkg::b_t    b,
	input  logic                b_ready,
	input  logic                ar_valid,
	input  axi_core_pkg::ar_t   ar,
	output logic                ar_ready,
	output logic                r_valid,
	output axi_core_pkg::r_t    r,
	input  logic                r_ready
);

	localparam int idx_w = $clog2(ram_words);

	typedef enum logic [1:0] {
		st_idle,
		st_b,
		st_r
	} state_t;

	state_t              state;
	axi_core_pkg::data_t mem [ram_words];
	axi_core_pkg::aw_t   aw_q;
	axi_core_pkg::w_t    w_q;
	logic                aw_held;
	logic                w_held;
	axi_core_pkg::addr_t wr_addr;
	axi_core_pkg::w_t    wr_beat;
	logic                wr_fire;
	logic                rd_fire;
	logic                wr_ok;
	logic                rd_ok;
	logic [idx_w-1:0]    wr_idx;
	logic [idx_w-1:0]    rd_idx;

	assign aw_ready = (state == st_idle) && !aw_held;
	assign w_ready  = (state == st_idle) && !w_held;
	// reads wait while any part of a write is pending
	assign ar_ready = (state == st_idle) && !aw_held && !w_held && !aw_valid && !w_valid;

	assign b_valid = (state == st_b);
	assign r_valid = (state == st_r);

	assign wr_addr = aw_held ? aw_q.addr : aw.addr;
	assign wr_beat = w_held ? w_q : w;
	assign wr_fire = (state == st_idle) && (aw_held || aw_valid) && (w_held || w_valid);
	assign rd_fire = ar_valid && ar_ready;

	assign wr_ok  = wr_addr[31:3] < ram_words;
	assign rd_ok  = ar.addr[31:3] < ram_words;
	assign wr_idx = wr_addr[idx_w+2:3];
	assign rd_idx = ar.addr[idx_w+2:3];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			aw_held <= 1'b0;
			w_held  <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (wr_fire) begin
						aw_held <= 1'b0;
						w_held  <= 1'b0;
						state   <= st_b;
					end else begin
						// half of a write arrived, keep it
						if (aw_valid && aw_ready) begin
							aw_held <= 1'b1;
						end
						if (w_valid && w_ready) begin
							w_held <= 1'b1;
						end
						if (rd_fire) begin
							state <= st_r;
						end
					end
				end
				st_b: begin
					if (b_ready) begin
						state <= st_idle;
					end
				end
				st_r: begin
					if (r_ready) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ram_words; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_fire && wr_ok) begin
			// byte merge under strobe
			for (int j = 0; j < axi_core_pkg::strb_w; j++) begin
				if (wr_beat.strb[j]) begin
					mem[wr_idx][8*j +: 8] <= wr_beat.data[8*j +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_valid && aw_ready) begin
			aw_q <= aw;
		end
		if (w_valid && w_ready) begin
			w_q <= w;
		end
		if (wr_fire) begin
			b.resp <= wr_ok ? axi_core_pkg::resp_okay : axi_core_pkg::resp_slverr;
		end
		if (rd_fire) begin
			r.data <= rd_ok ? mem[rd_idx] : '0;
			r.resp <= rd_ok ? axi_core_pkg::resp_okay : axi_core_pkg::resp_slverr;
		end
	end

endmodule

/* logic/axi_mem_subsys.sv */
////////////////////////////////////////////////////////////
// axi memory subsystem
// core bridge, forward channel slices and ram slave
////////////////////////////////////////////////////////////

module axi_mem_subsys #(
	parameter int ram_words = 256
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     fetch_req,
	input  axi_core_pkg::addr_t      fetch_pc,
	output logic                     fetch_ack,
	output axi_core_pkg::instr_t     fetch_instr,
	output logic                     fetch_err,
	input  logic                     mem_req,
	input  axi_core_pkg::mem_cmd_t   mem_cmd,
	output logic                     mem_ack,
	output axi_core_pkg::data_t      mem_rdata,
	output logic                     mem_err
);

	// master side of the slices
	logic              aw_valid_m, aw_ready_m;
	logic              w_valid_m, w_ready_m;
	logic              ar_valid_m, ar_ready_m;
	axi_core_pkg::aw_t aw_m;
	axi_core_pkg::w_t  w_m;
	axi_core_pkg::ar_t ar_m;

	// slave side of the slices
	logic              aw_valid_s, aw_ready_s;
	logic              w_valid_s, w_ready_s;
	logic              ar_valid_s, ar_ready_s;
	axi_core_pkg::aw_t aw_s;
	axi_core_pkg::w_t  w_s;
	axi_core_pkg::ar_t ar_s;

	// backward channels, no slices
	logic              b_valid, b_ready;
	logic              r_valid, r_ready;
	axi_core_pkg::b_t  b;
	axi_core_pkg::r_t  r;

	axi_core_master axi_core_master_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_req   (fetch_req),
		.fetch_pc    (fetch_pc),
		.fetch_ack   (fetch_ack),
		.fetch_instr (fetch_instr),
		.fetch_err   (fetch_err),
		.mem_req     (mem_req),
		.mem_cmd     (mem_cmd),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.mem_err     (mem_err),
		.aw_valid    (aw_valid_m),
		.aw          (aw_m),
		.aw_ready    (aw_ready_m),
		.w_valid     (w_valid_m),
		.w           (w_m),
		.w_ready     (w_ready_m),
		.b_valid     (b_valid),
		.b           (b),
		.b_ready     (b_ready),
		.ar_valid    (ar_valid_m),
		.ar          (ar_m),
		.ar_ready    (ar_ready_m),
		.r_valid     (r_valid),
		.r           (r),
		.r_ready     (r_ready)
	);

	axi_chan_slice #(.payload_t(axi_core_pkg::aw_t)) aw_slice_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (aw_valid_m),
		.in_data   (aw_m),
		.in_ready  (aw_ready_m),
		.out_valid (aw_valid_s),
		.out_data  (aw_s),
		.out_ready (aw_ready_s)
	);

	axi_chan_slice #(.payload_t(axi_core_pkg::w_t)) w_slice_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (w_valid_m),
		.in_data   (w_m),
		.in_ready  (w_ready_m),
		.out_valid (w_valid_s),
		.out_data  (w_s),
		.out_ready (w_ready_s)
	);

	axi_chan_slice #(.payload_t(axi_core_pkg::ar_t)) ar_slice_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (ar_valid_m),
		.in_data   (ar_m),
		.in_ready  (ar_ready_m),
		.out_valid (ar_valid_s),
		.out_data  (ar_s),
		.out_ready (ar_ready_s)
	);

	axi_ram_slave #(.ram_words(ram_words)) axi_ram_slave_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.aw_valid (aw_valid_s),
		.aw       (aw_s),
		.aw_ready (aw_ready_s),
		.w_valid  (w_valid_s),
		.w        (w_s),
		.w_ready  (w_ready_s),
		.b_valid  (b_valid),
		.b        (b),
		.b_ready  (b_ready),
		.ar_valid (ar_valid_s),
		.ar       (ar_s),
		.ar_ready (ar_ready_s),
		.r_valid  (r_valid),
		.r        (r),
		.r_ready  (r_ready)
	);

endmodule

/* tb/axi_mem_subsys_sva.sv */
////////////////////////////////////////////////////////////
// axi memory subsystem assertions
// four-phase rules on the fetch and load/store ports
////////////////////////////////////////////////////////////

module axi_mem_subsys_sva (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 fetch_req,
	input logic                 fetch_ack,
	input axi_core_pkg::instr_t fetch_instr,
	input logic                 mem_req,
	input logic                 mem_ack,
	input axi_core_pkg::data_t  mem_rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	fetch_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(fetch_ack) |-> fetch_req)
		else $error("fetch_ack rose while fetch_req was low");

	mem_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_ack) |-> mem_req)
		else $error("mem_ack rose while mem_req was low");

	// ack may only drop once the core has let go of req
	fetch_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(fetch_ack) |-> !$past(fetch_req))
		else $error("fetch_ack fell before fetch_req fell");

	mem_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(mem_ack) |-> !$past(mem_req))
		else $error("mem_ack fell before mem_req fell");

	fetch_instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_ack && $past(fetch_ack) |-> fetch_instr === $past(fetch_instr))
		else $error("fetch_instr changed while fetch_ack was high");

	mem_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ack && $past(mem_ack) |-> mem_rdata === $past(mem_rdata))
		else $error("mem_rdata changed while mem_ack was high");

	ack_low_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !fetch_ack && !mem_ack)
		else $error("an ack was high right after reset release");

endmodule

/* tb/axi_mem_subsys_tb.sv */
////////////////////////////////////////////////////////////
// axi memory subsystem testbench
// table of stores, loads and fetches through both core ports
////////////////////////////////////////////////////////////

module axi_mem_subsys_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ram_words    = 256;
	localparam int reset_cycles = 5;
	localparam int num_entries  = 16;
	localparam int cycle_limit  = 40 * num_entries + reset_cycles;

	typedef enum logic [1:0] {
		op_store,
		op_load,
		op_fetch,
		op_store_fetch
	} op_t;

	// for op_store_fetch the store goes to the aligned word and addr is the pc
	typedef struct packed {
		op_t                 op;
		axi_core_pkg::addr_t addr;
		axi_core_pkg::data_t data;
		axi_core_pkg::strb_t strb;
		axi_core_pkg::data_t exp_data;
		logic                exp_err;
	} entry_t;

	logic                   clk;
	logic                   rst_n;
	logic                   fetch_req;
	axi_core_pkg::addr_t    fetch_pc;
	logic                   fetch_ack;
	axi_core_pkg::instr_t   fetch_instr;
	logic                   fetch_err;
	logic                   mem_req;
	axi_core_pkg::mem_cmd_t mem_cmd;
	logic                   mem_ack;
	axi_core_pkg::data_t    mem_rdata;
	logic                   mem_err;

	entry_t      tests [num_entries];
	logic [31:0] lfsr;
	int          cycles;

	axi_mem_subsys #(.ram_words(ram_words)) axi_mem_subsys_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_req   (fetch_req),
		.fetch_pc    (fetch_pc),
		.fetch_ack   (fetch_ack),
		.fetch_instr (fetch_instr),
		.fetch_err   (fetch_err),
		.mem_req     (mem_req),
		.mem_cmd     (mem_cmd),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.mem_err     (mem_err)
	);

	bind axi_mem_subsys axi_mem_subsys_sva sva_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_req   (fetch_req),
		.fetch_ack   (fetch_ack),
		.fetch_instr (fetch_instr),
		.mem_req     (mem_req),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata)
	);

	always #50 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | lfsr[0];
		end
	endtask

	function automatic entry_t make_entry(input op_t op, input axi_core_pkg::addr_t addr,
			input axi_core_pkg::data_t data, input axi_core_pkg::strb_t strb,
			input axi_core_pkg::data_t exp_data, input logic exp_err);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.data     = data;
		e.strb     = strb;
		e.exp_data = exp_data;
		e.exp_err  = exp_err;
		return e;
	endfunction

	task automatic build_table();
		tests[0]  = make_entry(op_store, 32'h0000_0010,
			64'h0123_4567_89ab_cdef, 8'hff, 64'h0, 1'b0);
		tests[1]  = make_entry(op_load, 32'h0000_0010,
			64'h0, 8'h00, 64'h0123_4567_89ab_cdef, 1'b0);
		tests[2]  = make_entry(op_store, 32'h0000_0018,
			64'h1111_2222_3333_4444, 8'hff, 64'h0, 1'b0);
		// bytes 0, 1, 4 and 6 replaced
		tests[3]  = make_entry(op_store, 32'h0000_0018,
			64'haabb_ccdd_eeff_0099, 8'h53, 64'h0, 1'b0);
		tests[4]  = make_entry(op_load, 32'h0000_0018,
			64'h0, 8'h00, 64'h11bb_22dd_3333_0099, 1'b0);
		tests[5]  = make_entry(op_store, 32'h0000_0020,
			64'hfeed_f00d_1357_9bdf, 8'hff, 64'h0, 1'b0);
		tests[6]  = make_entry(op_fetch, 32'h0000_0020,
			64'h0, 8'h00, 64'h1357_9bdf, 1'b0);
		tests[7]  = make_entry(op_fetch, 32'h0000_0024,
			64'h0, 8'h00, 64'hfeed_f00d, 1'b0);
		// beyond a 256-word ram where the low index bits alias 0x10
		tests[8]  = make_entry(op_store, 32'h0000_0810,
			64'hdead_beef_dead_beef, 8'hff, 64'h0, 1'b1);
		tests[9]  = make_entry(op_load, 32'h0000_0810,
			64'h0, 8'h00, 64'h0, 1'b1);
		tests[10] = make_entry(op_load, 32'h0000_0010,
			64'h0, 8'h00, 64'h0123_4567_89ab_cdef, 1'b0);
		tests[11] = make_entry(op_load, 32'h0000_07f8,
			64'h0, 8'h00, 64'h0, 1'b0);
		tests[12] = make_entry(op_store_fetch, 32'h0000_002c,
			64'h0051_0113_00a0_0093, 8'hff, 64'h0051_0113, 1'b0);
		tests[13] = make_entry(op_fetch, 32'h0000_0028,
			64'h0, 8'h00, 64'h00a0_0093, 1'b0);
		tests[14] = make_entry(op_store_fetch, 32'h0000_1000,
			64'h5555_aaaa_5555_aaaa, 8'hff, 64'h0, 1'b1);
		tests[15] = make_entry(op_load, 32'h0000_0028,
			64'h0, 8'h00, 64'h0051_0113_00a0_0093, 1'b0);
	endtask

	task automatic mem_access(input logic we, input axi_core_pkg::addr_t addr,
			input axi_core_pkg::data_t wdata, input axi_core_pkg::strb_t strb,
			input axi_core_pkg::data_t exp_rdata, input logic exp_err,
			input logic want_rdata, output int ack_cycle);
		axi_core_pkg::mem_cmd_t cmd;
		axi_core_pkg::data_t    held_rdata;
		logic                   held_err;
		int                     hold;
		cmd.we    = we;
		cmd.addr  = addr;
		cmd.wdata = wdata;
		cmd.strb  = strb;
		@(posedge clk);
		mem_cmd <= cmd;
		mem_req <= 1'b1;
		do begin
			@(negedge clk);
		end while (!mem_ack);
		ack_cycle = cycles;
		check_value("mem_err", mem_err, exp_err);
		if (want_rdata) begin
			check_value("mem_rdata", mem_rdata, exp_rdata);
		end
		held_rdata = mem_rdata;
		held_err   = mem_err;
		// result has to stay put while req is still up
		random_bits(2, hold);
		repeat (hold) begin
			@(negedge clk);
			check_value("mem_ack", mem_ack, 1'b1);
			check_value("mem_rdata", mem_rdata, held_rdata);
			check_value("mem_err", mem_err, held_err);
		end
		@(posedge clk);
		mem_req <= 1'b0;
		do begin
			@(negedge clk);
		end while (mem_ack);
	endtask

	task automatic fetch_access(input axi_core_pkg::addr_t pc,
			input axi_core_pkg::instr_t exp_instr, input logic exp_err,
			output int ack_cycle);
		axi_core_pkg::instr_t held_instr;
		logic                 held_err;
		int                   hold;
		@(posedge clk);
		fetch_pc  <= pc;
		fetch_req <= 1'b1;
		do begin
			@(negedge clk);
		end while (!fetch_ack);
		ack_cycle = cycles;
		check_value("fetch_instr", fetch_instr, exp_instr);
		check_value("fetch_err", fetch_err, exp_err);
		held_instr = fetch_instr;
		held_err   = fetch_err;
		random_bits(2, hold);
		repeat (hold) begin
			@(negedge clk);
			check_value("fetch_ack", fetch_ack, 1'b1);
			check_value("fetch_instr", fetch_instr, held_instr);
			check_value("fetch_err", fetch_err, held_err);
		end
		@(posedge clk);
		fetch_req <= 1'b0;
		do begin
			@(negedge clk);
		end while (fetch_ack);
	endtask

	task automatic run_entry(input entry_t e);
		int mem_cycle;
		int fetch_cycle;
		case (e.op)
			op_store: begin
				mem_access(1'b1, e.addr, e.data, e.strb, '0, e.exp_err, 1'b0, mem_cycle);
			end
			op_load: begin
				mem_access(1'b0, e.addr, '0, '0, e.exp_data, e.exp_err, 1'b1, mem_cycle);
			end
			op_fetch: begin
				fetch_access(e.addr, e.exp_data[31:0], e.exp_err, fetch_cycle);
			end
			default: begin
				// both ports raised on the same edge
				fork
					mem_access(1'b1, {e.addr[31:3], 3'b000}, e.data, e.strb, '0,
						e.exp_err, 1'b0, mem_cycle);
					fetch_access(e.addr, e.exp_data[31:0], e.exp_err, fetch_cycle);
				join
				if (mem_cycle > fetch_cycle) begin
					abort_run("data port was acknowledged after the fetch port");
				end
			end
		endcase
	endtask

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
	end

	initial begin
		int gap;
		clk       = 1'b0;
		rst_n     = 1'b0;
		fetch_req = 1'b0;
		fetch_pc  = '0;
		mem_req   = 1'b0;
		mem_cmd   = '0;
		lfsr      = 32'hb3e6ae66;
		build_table();
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("fetch_ack", fetch_ack, 1'b0);
		check_value("mem_ack", mem_ack, 1'b0);
		for (int i = 0; i < num_entries; i++) begin
			random_bits(3, gap);
			repeat (gap) @(posedge clk);
			run_entry(tests[i]);
		end
		$display("Test OK");
		$finish;
	end

endmodule

/* vlog.f */
logic/axi_core_pkg.sv
logic/axi_chan_slice.sv
logic/axi_core_master.sv
logic/axi_ram_slave.sv
logic/axi_mem_subsys.sv
tb/axi_mem_subsys_sva.sv
tb/axi_mem_subsys_tb.sv
